/* Makefile */
TOP := eth_link_fifo_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the loopback testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* bench/eth_link_fifo_tb.sv */
/*
 * Loopback testbench for the Ethernet-style link endpoint
 * Feeds link_tx_word back into link_rx_word and checks frames against a model
 */
`timescale 1ns/100ps
`default_nettype none

`include "eth_defs.svh"

module eth_link_fifo_tb;

    localparam int RX_DEPTH = 2 ** `ETH_RX_FIFO_ADDR_WIDTH;
    localparam int TIMEOUT  = 5000;

    // Bit positions inside the status bundle
    localparam int FCS     = 0;
    localparam int RX_GOOD = 2;
    localparam int RX_BAD  = 3;
    localparam int RX_OVER = 4;
    localparam int TX_GOOD = 5;
    localparam int TX_BAD  = 6;

    typedef eth_pkg::axis_beat_t beat_q_t[$];

    logic                       logic_clk;
    logic                       logic_rst;
    eth_pkg::axis_beat_t        tx_axis;
    logic                       tx_axis_valid;
    logic                       tx_axis_ready;
    eth_pkg::axis_beat_t        rx_axis;
    logic                       rx_axis_valid;
    logic                       rx_axis_ready = 1'b0;
    eth_pkg::link_word_t        link_tx_word;
    eth_pkg::link_word_t        link_rx_word;
    logic [7:0]                 ifg_delay;
    eth_pkg::link_status_t      status;

    integer                     seed = 32'hc321;
    // 0 always ready, 1 held low, 2 random back-pressure
    int                         rx_mode = 0;
    int                         rx_occ = 0;
    int                         corrupt_index = -1;
    int                         data_word_count = 0;
    int                         idle_seen = 0;
    int                         gap_need = 1;
    logic                       in_gap = 1'b0;
    int                         ifg_values [3] = '{0, 3, 12};
    int                         seen_cnt [8] = '{default: 0};
    int                         exp_cnt [8] = '{default: 0};
    string                      cnt_name [8] = '{
        "rx_error_bad_fcs", "rx_error_bad_frame", "rx_fifo.good_frame", "rx_fifo.bad_frame",
        "rx_fifo.overflow", "tx_fifo.good_frame", "tx_fifo.bad_frame", "tx_fifo.overflow"
    };
    beat_q_t                    frame;
    beat_q_t                    exp_q;
    logic [`ETH_DATA_WIDTH-1:0] check_q [$];

    eth_link_fifo eth_link_fifo_inst (.*);

    always #4 logic_clk = ~logic_clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
        else fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    // Keep-masked XOR of all data words
    function automatic logic [`ETH_DATA_WIDTH-1:0] frame_check(input beat_q_t beats);
        logic [`ETH_DATA_WIDTH-1:0] acc;
        acc = '0;
        foreach (beats[i]) begin
            for (int b = 0; b < `ETH_KEEP_WIDTH; b++) begin
                if (beats[i].keep[b]) begin
                    acc[b*8 +: 8] = acc[b*8 +: 8] ^ beats[i].data[b*8 +: 8];
                end
            end
        end
        return acc;
    endfunction

    // Expected fate of the frame in both FIFOs
    function automatic void model_frame(input bit bad, input bit corrupt);
        if (bad) begin
            exp_cnt[TX_BAD]++;
            return;
        end
        exp_cnt[TX_GOOD]++;
        check_q.push_back(frame_check(frame));
        if (corrupt) begin
            exp_cnt[RX_BAD]++;
            exp_cnt[FCS]++;
        end else if (rx_mode == 1 && frame.size() > RX_DEPTH - rx_occ) begin
            exp_cnt[RX_OVER]++;
        end else begin
            rx_occ += frame.size();
            exp_cnt[RX_GOOD]++;
            foreach (frame[i]) begin
                exp_q.push_back(frame[i]);
            end
        end
    endfunction

    function automatic int rand_len(input int max_len);
        return 1 + int'($unsigned($random(seed)) % max_len);
    endfunction

    function automatic void build_frame(input int len, input bit bad);
        eth_pkg::axis_beat_t beat;
        int                  keep_sel;
        frame.delete();
        keep_sel = int'($unsigned($random(seed)) % 4);
        for (int i = 0; i < len; i++) begin
            beat.data = $random(seed);
            beat.keep = (i == len - 1) ? 4'hf >> (3 - keep_sel) : 4'hf;
            beat.last = (i == len - 1);
            beat.user = bad && (i == len - 1);
            frame.push_back(beat);
        end
    endfunction

    task automatic drive_frame();
        int gap;
        int cycles;
        foreach (frame[i]) begin
            gap = int'($unsigned($random(seed)) % 3);
            for (int g = 0; g < gap; g++) begin
                @(negedge logic_clk);
                tx_axis_valid = 1'b0;
            end
            @(negedge logic_clk);
            tx_axis       = frame[i];
            tx_axis_valid = 1'b1;
            cycles = 0;
            while (!tx_axis_ready) begin
                @(negedge logic_clk);
                cycles++;
                if (cycles > TIMEOUT) fail_run("timeout waiting for tx_axis_ready");
            end
        end
        @(negedge logic_clk);
        tx_axis_valid = 1'b0;
    endtask

    task automatic run_frame(input int len, input bit bad, input bit corrupt);
        build_frame(len, bad);
        model_frame(bad, corrupt);
        // Next data word on the link is this frame's first
        if (corrupt) corrupt_index = data_word_count;
        drive_frame();
    endtask

    task automatic wait_link_done(input string phase);
        int cycles;
        cycles = 0;
        while (check_q.size() != 0
               || seen_cnt[TX_GOOD] + seen_cnt[TX_BAD] != exp_cnt[TX_GOOD] + exp_cnt[TX_BAD]
               || seen_cnt[RX_GOOD] + seen_cnt[RX_BAD] + seen_cnt[RX_OVER]
                  != exp_cnt[RX_GOOD] + exp_cnt[RX_BAD] + exp_cnt[RX_OVER]) begin
            @(negedge logic_clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("timeout waiting for %s frames to cross the link", phase));
            end
        end
    endtask

    task automatic wait_drained(input string phase);
        int cycles;
        wait_link_done(phase);
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge logic_clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("timeout waiting for rx_axis to deliver %s frames", phase));
            end
        end
    endtask

    task automatic check_counts();
        for (int i = 0; i < 8; i++) begin
            check_value({cnt_name[i], " pulses"}, exp_cnt[i], seen_cnt[i]);
        end
    endtask

    // Loopback with a single-bit flip on one chosen data word
    always_comb begin
        link_rx_word = link_tx_word;
        if (link_tx_word.kind == eth_pkg::LINK_DATA && data_word_count == corrupt_index) begin
            link_rx_word.data[0] = ~link_tx_word.data[0];
        end
    end

    always @(posedge logic_clk) begin
        if (link_tx_word.kind == eth_pkg::LINK_DATA) begin
            data_word_count <= data_word_count + 1;
        end
    end

    always @(negedge logic_clk) begin
        if (!logic_rst) begin
            for (int i = 0; i < 8; i++) begin
                if (status[i]) seen_cnt[i]++;
            end
        end
    end

    // Terminate check values and inter-frame gaps on the link
    always @(negedge logic_clk) begin
        logic [`ETH_DATA_WIDTH-1:0] expected_check;
        if (!logic_rst) begin
            case (link_tx_word.kind)
                eth_pkg::LINK_TERM: begin
                    assert (check_q.size() != 0)
                    else fail_run("terminate word on the link with no frame outstanding");
                    expected_check = check_q.pop_front();
                    assert (link_tx_word.data == expected_check)
                    else fail_run($sformatf("mismatch link_tx_word.data expected %h actual %h",
                                            expected_check, link_tx_word.data));
                    gap_need  = (ifg_delay > 8'd1) ? int'(ifg_delay) : 1;
                    idle_seen = 0;
                    in_gap    = 1'b1;
                end
                eth_pkg::LINK_DATA: begin
                    if (in_gap) begin
                        assert (idle_seen >= gap_need)
                        else fail_run($sformatf("only %0d idle words after a terminate, %0d needed",
                                                idle_seen, gap_need));
                    end
                    in_gap = 1'b0;
                end
                default: begin
                    idle_seen++;
                end
            endcase
        end
    end

    // Picks rx_axis_ready and compares each delivered beat
    always @(negedge logic_clk) begin
        eth_pkg::axis_beat_t expected;
        if (!logic_rst) begin
            case (rx_mode)
                1: rx_axis_ready = 1'b0;
                2: rx_axis_ready = ($unsigned($random(seed)) % 3) != 0;
                default: rx_axis_ready = 1'b1;
            endcase
            if (rx_axis_valid && rx_axis_ready) begin
                assert (exp_q.size() != 0)
                else fail_run("rx_axis delivered a beat that no frame accounts for");
                expected = exp_q.pop_front();
                assert (rx_axis == expected)
                else fail_run($sformatf("mismatch rx_axis expected %h actual %h",
                                        expected, rx_axis));
            end
        end
    end

    initial begin
        logic_clk     = 1'b0;
        logic_rst     = 1'b1;
        tx_axis       = '0;
        tx_axis_valid = 1'b0;
        ifg_delay     = 8'd4;
        repeat (10) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;
        @(negedge logic_clk);
        check_value("rx_axis_valid", 0, int'(rx_axis_valid));
        check_value("status", 0, int'(status));
        check_value("link_tx_word.kind", int'(eth_pkg::LINK_IDLE), int'(link_tx_word.kind));
        check_value("tx_axis_ready", 1, int'(tx_axis_ready));

        for (int n = 0; n < 20; n++) begin
            run_frame(rand_len(16), 1'b0, 1'b0);
        end
        wait_drained("random good");
        check_counts();

        // Bad frame then a good one
        run_frame(rand_len(16), 1'b1, 1'b0);
        run_frame(rand_len(16), 1'b0, 1'b0);
        wait_drained("bad mark");
        check_counts();

        run_frame(rand_len(16), 1'b0, 1'b1);
        run_frame(rand_len(16), 1'b0, 1'b0);
        wait_drained("corrupted");
        check_counts();

        for (int k = 0; k < 3; k++) begin
            ifg_delay = 8'(ifg_values[k]);
            for (int n = 0; n < 4; n++) begin
                run_frame(rand_len(4), 1'b0, 1'b0);
            end
            wait_drained("gap");
            check_counts();
        end

        // Receive FIFO held, then drained under back-pressure
        rx_mode = 1;
        rx_occ  = 0;
        for (int n = 0; n < 8; n++) begin
            run_frame(8 + rand_len(8), 1'b0, 1'b0);
        end
        wait_link_done("held receive");
        check_counts();
        rx_mode = 2;
        wait_drained("released receive");
        check_counts();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/eth_defs.svh */
/*
 * Ethernet link endpoint widths and FIFO depths
 */
`ifndef ETH_DEFS_SVH
`define ETH_DEFS_SVH

// Stream and link data path
`define ETH_DATA_WIDTH 32
`define ETH_KEEP_WIDTH 4

// FIFO depths as log2 of beats
`define ETH_TX_FIFO_ADDR_WIDTH 6
`define ETH_RX_FIFO_ADDR_WIDTH 6

`endif

/* source/eth_link_fifo.sv */
/*
 * Ethernet-style link endpoint with transmit and receive frame FIFOs
 */
`timescale 1ns/100ps
`default_nettype none

`include "eth_defs.svh"

module eth_link_fifo (
    input  wire                        logic_clk,
    input  wire                        logic_rst,

    input  wire eth_pkg::axis_beat_t   tx_axis,
    input  wire                        tx_axis_valid,
    output logic                       tx_axis_ready,

    output eth_pkg::axis_beat_t        rx_axis,
    output logic                       rx_axis_valid,
    input  wire                        rx_axis_ready,

    output eth_pkg::link_word_t        link_tx_word,
    input  wire eth_pkg::link_word_t   link_rx_word,

    input  wire [7:0]                  ifg_delay,

    output eth_pkg::link_status_t      status
);

    eth_pkg::axis_beat_t   tx_fifo_beat;
    logic                  tx_fifo_valid;
    logic                  tx_fifo_ready;
    eth_pkg::axis_beat_t   rx_fifo_beat;
    logic                  rx_fifo_valid;
    eth_pkg::fifo_status_t tx_fifo_status;
    eth_pkg::fifo_status_t rx_fifo_status;
    logic                  rx_error_bad_frame;
    logic                  rx_error_bad_fcs;

    assign status = '{
        tx_fifo:            tx_fifo_status,
        rx_fifo:            rx_fifo_status,
        rx_error_bad_frame: rx_error_bad_frame,
        rx_error_bad_fcs:   rx_error_bad_fcs
    };

    // Transmit side holds back until a source frame is complete
    frame_fifo #(
        .ADDR_WIDTH(`ETH_TX_FIFO_ADDR_WIDTH),
        .DROP_WHEN_FULL(1'b0)
    ) tx_fifo (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .in_beat(tx_axis),
        .in_valid(tx_axis_valid),
        .in_ready(tx_axis_ready),
        .out_beat(tx_fifo_beat),
        .out_valid(tx_fifo_valid),
        .out_ready(tx_fifo_ready),
        .status(tx_fifo_status)
    );

    link_tx link_tx_inst (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .frame_beat(tx_fifo_beat),
        .frame_valid(tx_fifo_valid),
        .frame_ready(tx_fifo_ready),
        .ifg_delay(ifg_delay),
        .link_word(link_tx_word)
    );

    link_rx link_rx_inst (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .link_word(link_rx_word),
        .frame_beat(rx_fifo_beat),
        .frame_valid(rx_fifo_valid),
        .error_bad_frame(rx_error_bad_frame),
        .error_bad_fcs(rx_error_bad_fcs)
    );

    // Link has no back-pressure, so frames that do not fit are dropped
    frame_fifo #(
        .ADDR_WIDTH(`ETH_RX_FIFO_ADDR_WIDTH),
        .DROP_WHEN_FULL(1'b1)
    ) rx_fifo (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .in_beat(rx_fifo_beat),
        .in_valid(rx_fifo_valid),
        .in_ready(),
        .out_beat(rx_axis),
        .out_valid(rx_axis_valid),
        .out_ready(rx_axis_ready),
        .status(rx_fifo_status)
    );

endmodule

`default_nettype wire

/* source/eth_pkg.sv */
/*
 * Ethernet link endpoint types
 * Stream beats, link words, status bundles and the keep-masked check helper
 */
`default_nettype none

`include "eth_defs.svh"

package eth_pkg;

    typedef struct packed {
        logic [`ETH_DATA_WIDTH-1:0] data;
        logic [`ETH_KEEP_WIDTH-1:0] keep;
        logic                       last;
        logic                       user;
    } axis_beat_t;

    typedef enum logic [1:0] {
        LINK_IDLE = 2'd0,
        LINK_DATA = 2'd1,
        LINK_TERM = 2'd2
    } link_kind_t;

    // On a TERM word the data field carries the frame check
    typedef struct packed {
        link_kind_t                 kind;
        logic [`ETH_DATA_WIDTH-1:0] data;
        logic [`ETH_KEEP_WIDTH-1:0] keep;
    } link_word_t;

    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

    typedef struct packed {
        fifo_status_t tx_fifo;
        fifo_status_t rx_fifo;
        logic         rx_error_bad_frame;
        logic         rx_error_bad_fcs;
    } link_status_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_DATA,
        TX_TERM,
        TX_GAP
    } tx_state_t;

    // Zero the bytes whose keep bit is clear
    function automatic logic [`ETH_DATA_WIDTH-1:0] keep_mask(
        input logic [`ETH_DATA_WIDTH-1:0] data,
        input logic [`ETH_KEEP_WIDTH-1:0] keep
    );
        logic [`ETH_DATA_WIDTH-1:0] masked;
        for (int i = 0; i < `ETH_KEEP_WIDTH; i++) begin
            masked[i*8 +: 8] = keep[i] ? data[i*8 +: 8] : 8'h00;
        end
        return masked;
    endfunction

endpackage

`default_nettype wire

/* source/frame_fifo.sv */
/*
 * Store-and-forward frame FIFO
 * Drops frames marked bad and, optionally, frames that do not fit
 */
`timescale 1ns/100ps
`default_nettype none

module frame_fifo #(
    parameter int ADDR_WIDTH     = 6,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  wire                        logic_clk,
    input  wire                        logic_rst,

    input  wire eth_pkg::axis_beat_t   in_beat,
    input  wire                        in_valid,
    output logic                       in_ready,

    output eth_pkg::axis_beat_t        out_beat,
    output logic                       out_valid,
    input  wire                        out_ready,

    output eth_pkg::fifo_status_t      status
);

    // One extra pointer bit tells full from empty
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    eth_pkg::axis_beat_t  mem [2**ADDR_WIDTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] wr_ptr_commit;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic                 full;
    logic                 drop_frame;
    logic                 in_xfer;
    logic                 store_beat;

    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign in_ready = DROP_WHEN_FULL ? 1'b1 : !full;
    assign in_xfer  = in_valid && in_ready;

    // Once a frame hits a full memory, the rest of it is discarded
    assign store_beat = in_xfer && !(DROP_WHEN_FULL && (full || drop_frame));

    always_ff @(posedge logic_clk) begin
        if (store_beat) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_beat;
        end
    end

    // Write side and frame commit
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr        <= '0;
            wr_ptr_commit <= '0;
            drop_frame    <= 1'b0;
            status        <= '0;
        end else begin
            status <= '0;
            if (in_xfer) begin
                if (!store_beat) begin
                    if (in_beat.last) begin
                        // Discard the partial frame
                        wr_ptr          <= wr_ptr_commit;
                        drop_frame      <= 1'b0;
                        status.overflow <= 1'b1;
                    end else begin
                        drop_frame <= 1'b1;
                    end
                end else if (in_beat.last) begin
                    if (in_beat.user) begin
                        wr_ptr           <= wr_ptr_commit;
                        status.bad_frame <= 1'b1;
                    end else begin
                        wr_ptr            <= wr_ptr + 1'b1;
                        wr_ptr_commit     <= wr_ptr + 1'b1;
                        status.good_frame <= 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Only committed frames are readable
    assign out_valid = rd_ptr != wr_ptr_commit;
    assign out_beat  = mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr <= '0;
        end else if (out_valid && out_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/link_rx.sv */
/*
 * Link receiver
 * Rebuilds frames from link words and checks the terminate word's check value
 */
`timescale 1ns/100ps
`default_nettype none

`include "eth_defs.svh"

module link_rx (
    input  wire                        logic_clk,
    input  wire                        logic_rst,

    input  wire eth_pkg::link_word_t   link_word,

    output eth_pkg::axis_beat_t        frame_beat,
    output logic                       frame_valid,

    output logic                       error_bad_frame,
    output logic                       error_bad_fcs
);

    logic [`ETH_DATA_WIDTH-1:0] pend_data;
    logic [`ETH_KEEP_WIDTH-1:0] pend_keep;
    logic                       pend_valid;
    logic [`ETH_DATA_WIDTH-1:0] check;
    logic [`ETH_DATA_WIDTH-1:0] word_masked;
    logic                       fcs_mismatch;

    assign word_masked  = eth_pkg::keep_mask(link_word.data, link_word.keep);
    assign fcs_mismatch = check != link_word.data;

    // Data path, the pending beat goes out when the next word shows up
    always_ff @(posedge logic_clk) begin
        frame_beat.data <= pend_data;
        frame_beat.keep <= pend_keep;
        case (link_word.kind)
            eth_pkg::LINK_DATA: begin
                frame_beat.last <= 1'b0;
                frame_beat.user <= 1'b0;
                pend_data       <= link_word.data;
                pend_keep       <= link_word.keep;
                check           <= pend_valid ? (check ^ word_masked) : word_masked;
            end
            eth_pkg::LINK_TERM: begin
                frame_beat.last <= 1'b1;
                frame_beat.user <= fcs_mismatch;
            end
            default: begin
                // Frame cut short by idle
                frame_beat.last <= 1'b1;
                frame_beat.user <= 1'b1;
            end
        endcase
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            pend_valid      <= 1'b0;
            frame_valid     <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            frame_valid     <= pend_valid;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
            case (link_word.kind)
                eth_pkg::LINK_DATA: begin
                    pend_valid <= 1'b1;
                end
                eth_pkg::LINK_TERM: begin
                    pend_valid      <= 1'b0;
                    error_bad_fcs   <= pend_valid && fcs_mismatch;
                    // Terminate with no frame in progress
                    error_bad_frame <= !pend_valid;
                end
                default: begin
                    pend_valid      <= 1'b0;
                    error_bad_frame <= pend_valid;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/link_tx.sv */
/*
 * Link transmitter
 * Sends frame data words, a terminate word with the check, then an idle gap
 */
`timescale 1ns/100ps
`default_nettype none

`include "eth_defs.svh"

module link_tx (
    input  wire                        logic_clk,
    input  wire                        logic_rst,

    input  wire eth_pkg::axis_beat_t   frame_beat,
    input  wire                        frame_valid,
    output logic                       frame_ready,

    input  wire [7:0]                  ifg_delay,

    output eth_pkg::link_word_t        link_word
);

    localparam eth_pkg::link_word_t IDLE_WORD = '{
        kind: eth_pkg::LINK_IDLE,
        data: '0,
        keep: '0
    };

    eth_pkg::tx_state_t         state;
    logic [7:0]                 gap_count;
    logic [`ETH_DATA_WIDTH-1:0] check;
    logic                       beat_xfer;

    assign frame_ready = (state == eth_pkg::TX_IDLE) || (state == eth_pkg::TX_DATA);
    assign beat_xfer   = frame_valid && frame_ready;

    // First beat of a frame seeds the check
    always_ff @(posedge logic_clk) begin
        if (beat_xfer) begin
            if (state == eth_pkg::TX_IDLE) begin
                check <= eth_pkg::keep_mask(frame_beat.data, frame_beat.keep);
            end else begin
                check <= check ^ eth_pkg::keep_mask(frame_beat.data, frame_beat.keep);
            end
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state     <= eth_pkg::TX_IDLE;
            gap_count <= '0;
            link_word <= IDLE_WORD;
        end else begin
            case (state)
                eth_pkg::TX_IDLE, eth_pkg::TX_DATA: begin
                    if (beat_xfer) begin
                        link_word.kind <= eth_pkg::LINK_DATA;
                        link_word.data <= frame_beat.data;
                        link_word.keep <= frame_beat.keep;
                        state <= frame_beat.last ? eth_pkg::TX_TERM : eth_pkg::TX_DATA;
                    end else begin
                        link_word <= IDLE_WORD;
                    end
                end
                eth_pkg::TX_TERM: begin
                    link_word.kind <= eth_pkg::LINK_TERM;
                    link_word.data <= check;
                    link_word.keep <= '0;
                    // At least one idle word even with a zero gap setting
                    gap_count <= (ifg_delay > 8'd1) ? ifg_delay : 8'd1;
                    state     <= eth_pkg::TX_GAP;
                end
                eth_pkg::TX_GAP: begin
                    link_word <= IDLE_WORD;
                    gap_count <= gap_count - 8'd1;
                    if (gap_count == 8'd1) begin
                        state <= eth_pkg::TX_IDLE;
                    end
                end
                default: begin
                    state <= eth_pkg::TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/eth_pkg.sv
source/frame_fifo.sv
source/link_tx.sv
source/link_rx.sv
source/eth_link_fifo.sv
bench/eth_link_fifo_tb.sv
